//--- src/fetch_pkg.sv
// instruction fetch shared types
`default_nettype none

package fetch_pkg;

  // widths
  localparam int PC_WD        = 32;
  localparam int INST_WD      = 32;
  localparam int SRAM_DATA_WD = 64;
  localparam int SRAM_ADDR_WD = 32;
  localparam int OPC_WD       = 7;

  localparam logic [PC_WD-1:0] PC_RESETVAL = 32'h8000_0000; // first fetched address
  localparam logic [PC_WD-1:0] INST_BYTES  = 32'd4;          // sequential step

  // control-flow opcodes seen by predecode
  localparam logic [OPC_WD-1:0] OPC_BRANCH = 7'b1100011;
  localparam logic [OPC_WD-1:0] OPC_JAL    = 7'b1101111;
  localparam logic [OPC_WD-1:0] OPC_JALR   = 7'b1100111;

  typedef logic [PC_WD-1:0]        pc_t;
  typedef logic [INST_WD-1:0]      inst_t;
  typedef logic [SRAM_DATA_WD-1:0] sram_data_t;

  // from decode, 34 bits
  typedef struct packed {
    logic stall;  // load-to-branch, no fetch this cycle
    logic taken;  // redirect
    pc_t  target;
  } br_bus_t;

  typedef struct packed {
    logic is_branch;
    logic is_jal;
    logic is_jalr;
  } predecode_t;

  // to decode, 67 bits
  typedef struct packed {
    pc_t        pc;
    inst_t      inst;
    predecode_t predecode;
  } fs_to_ds_bus_t;

endpackage

`default_nettype wire

//--- src/fetch_pc.sv
// fetch program counter
`timescale 1ns/100ps
`default_nettype none

module fetch_pc (
  input  logic              i_clk,
  input  logic              i_arst_n,
  input  logic              i_load,       // request accepted this cycle
  input  logic              i_br_taken,
  input  fetch_pkg::pc_t    i_br_target,
  output fetch_pkg::pc_t    o_pc,
  output fetch_pkg::pc_t    o_inst_sram_addr
);

  fetch_pkg::pc_t                      pc_q;
  fetch_pkg::pc_t                      seq_pc;
  logic [fetch_pkg::SRAM_ADDR_WD-1:0] req_addr;

  assign seq_pc = pc_q + fetch_pkg::INST_BYTES;

  // redirect wins over the sequential address
  always_comb begin
    if (i_br_taken) begin
      req_addr = i_br_target;
    end else begin
      req_addr = seq_pc;
    end
  end

  // one step behind reset PC so the first request is PC_RESETVAL
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q <= fetch_pkg::PC_RESETVAL - fetch_pkg::INST_BYTES;
    end else if (i_load) begin
      pc_q <= req_addr;
    end
  end

  assign o_pc             = pc_q;
  assign o_inst_sram_addr = req_addr;

endmodule

`default_nettype wire

//--- src/fetch_ifu.sv
// instruction select and predecode
`timescale 1ns/100ps
`default_nettype none

module fetch_ifu (
  input  logic                    i_pc_align,        // pc[2]
  input  fetch_pkg::sram_data_t   i_inst_sram_rdata,
  output fetch_pkg::inst_t        o_inst,
  output fetch_pkg::predecode_t   o_predecode
);

  fetch_pkg::inst_t              inst_lo;
  fetch_pkg::inst_t              inst_hi;
  logic [fetch_pkg::OPC_WD-1:0] opcode;

  // 64-bit read holds two words
  assign inst_lo = i_inst_sram_rdata[fetch_pkg::INST_WD-1:0];
  assign inst_hi = i_inst_sram_rdata[fetch_pkg::SRAM_DATA_WD-1 -: fetch_pkg::INST_WD];

  always_comb begin
    if (i_pc_align) begin
      o_inst = inst_hi;
    end else begin
      o_inst = inst_lo;
    end
  end

  assign opcode = o_inst[fetch_pkg::OPC_WD-1:0];

  // opcode match only, rest is left to decode
  always_comb begin
    o_predecode.is_branch = (opcode == fetch_pkg::OPC_BRANCH);
    o_predecode.is_jal    = (opcode == fetch_pkg::OPC_JAL);
    o_predecode.is_jalr   = (opcode == fetch_pkg::OPC_JALR);
  end

endmodule

`default_nettype wire

//--- src/fetch_hold_buf.sv
// fetch response hold buffer
`timescale 1ns/100ps
`default_nettype none

module fetch_hold_buf (
  input  logic                      i_clk,
  input  logic                      i_arst_n,
  input  logic                      i_save,   // response arrived, decode busy
  input  logic                      i_clear,  // decode takes it
  input  fetch_pkg::fs_to_ds_bus_t  i_bus,
  output fetch_pkg::fs_to_ds_bus_t  o_bus,
  output logic                      o_full
);

  fetch_pkg::fs_to_ds_bus_t bus_q;
  logic                     full_q;

  // the SRAM gives its data once, so keep it here until decode is ready
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      full_q <= 1'b0;
    end else if (i_clear) begin
      full_q <= 1'b0;
    end else if (i_save) begin
      full_q <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_clear) begin
      bus_q <= '0;        // clear wins
    end else if (i_save) begin
      bus_q <= i_bus;
    end
  end

  assign o_bus  = bus_q;
  assign o_full = full_q;

endmodule

`default_nettype wire

//--- src/fetch_stage.sv
// pre-fetch and fetch stage
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
  input  logic                      i_clk,
  input  logic                      i_arst_n,
  // decode side
  input  logic                      i_ds_allowin,
  input  fetch_pkg::br_bus_t        i_br_bus,
  output logic                      o_fs_to_ds_valid,
  output fetch_pkg::fs_to_ds_bus_t  o_fs_to_ds_bus,
  // inst sram
  output logic                      o_inst_sram_ren,
  output fetch_pkg::pc_t            o_inst_sram_addr,
  input  fetch_pkg::sram_data_t     i_inst_sram_rdata,
  input  logic                      i_inst_sram_addr_ok,
  input  logic                      i_inst_sram_data_ok
);

  logic                      pre_fs_ready_go;
  logic                      fs_load;
  logic                      fs_valid;
  logic                      fs_ready_go;
  logic                      fs_allowin;
  fetch_pkg::pc_t            fs_pc;
  fetch_pkg::inst_t          fs_inst;
  fetch_pkg::predecode_t     fs_predecode;
  fetch_pkg::fs_to_ds_bus_t  live_bus;
  fetch_pkg::fs_to_ds_bus_t  hold_bus;
  logic                      hold_full;
  logic                      hold_save;

  // pre-fetch: request accepted unless decode asks for a stall
  assign pre_fs_ready_go = ~i_br_bus.stall & i_inst_sram_addr_ok;
  assign fs_load         = pre_fs_ready_go & fs_allowin;
  assign o_inst_sram_ren = fs_allowin;   // one request in flight at most

  // fetch: waits for data_ok or a held packet
  assign fs_ready_go = i_inst_sram_data_ok | hold_full;
  assign fs_allowin  = ~fs_valid | (fs_ready_go & i_ds_allowin);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      fs_valid <= 1'b0;
    end else if (fs_allowin) begin
      fs_valid <= pre_fs_ready_go;
    end
  end

  assign o_fs_to_ds_valid = fs_valid & fs_ready_go;

  assign live_bus = '{pc: fs_pc, inst: fs_inst, predecode: fs_predecode};

  // held packet has priority, live path is combinational from rdata
  assign o_fs_to_ds_bus = hold_full ? hold_bus : live_bus;

  assign hold_save = i_inst_sram_data_ok & ~i_ds_allowin;

  fetch_pc u_pc (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_load           (fs_load),
    .i_br_taken       (i_br_bus.taken),
    .i_br_target      (i_br_bus.target),
    .o_pc             (fs_pc),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  fetch_ifu u_ifu (
    .i_pc_align        (fs_pc[2]),      // upper or lower word of the 64-bit read
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .o_inst            (fs_inst),
    .o_predecode       (fs_predecode)
  );

  fetch_hold_buf u_hold_buf (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_save   (hold_save),
    .i_clear  (i_ds_allowin),
    .i_bus    (live_bus),
    .o_bus    (hold_bus),
    .o_full   (hold_full)
  );

endmodule

`default_nettype wire

//--- src/fetch_top.sv
// instruction fetch top
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
  input  logic                      i_clk,
  input  logic                      i_arst_n,
  // decode
  input  logic                      i_ds_allowin,
  input  fetch_pkg::br_bus_t        i_br_bus,
  output logic                      o_fs_to_ds_valid,
  output fetch_pkg::fs_to_ds_bus_t  o_fs_to_ds_bus,
  // inst sram
  output logic                      o_inst_sram_ren,
  output fetch_pkg::pc_t            o_inst_sram_addr,
  input  fetch_pkg::sram_data_t     i_inst_sram_rdata,
  input  logic                      i_inst_sram_addr_ok,
  input  logic                      i_inst_sram_data_ok
);

  fetch_stage u_fetch_stage (
    .i_clk               (i_clk),
    .i_arst_n            (i_arst_n),
    .i_ds_allowin        (i_ds_allowin),
    .i_br_bus            (i_br_bus),
    .o_fs_to_ds_valid    (o_fs_to_ds_valid),
    .o_fs_to_ds_bus      (o_fs_to_ds_bus),
    .o_inst_sram_ren     (o_inst_sram_ren),
    .o_inst_sram_addr    (o_inst_sram_addr),
    .i_inst_sram_rdata   (i_inst_sram_rdata),
    .i_inst_sram_addr_ok (i_inst_sram_addr_ok),
    .i_inst_sram_data_ok (i_inst_sram_data_ok)
  );

endmodule

`default_nettype wire

//--- tb/fetch_checker.sv
// fetch port assertions
`timescale 1ns/100ps
`default_nettype none

module fetch_checker (
  input logic                      i_clk,
  input logic                      i_arst_n,
  input logic                      i_ds_allowin,
  input fetch_pkg::br_bus_t        i_br_bus,
  input logic                      i_fs_to_ds_valid,
  input fetch_pkg::fs_to_ds_bus_t  i_fs_to_ds_bus,
  input logic                      i_inst_sram_ren,
  input logic                      i_inst_sram_addr_ok,
  input logic                      i_inst_sram_data_ok
);

  logic req_pending;  // request accepted, data not yet back

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      req_pending <= 1'b0;
    end else if (i_inst_sram_ren & i_inst_sram_addr_ok & ~i_br_bus.stall) begin
      req_pending <= 1'b1;  // new load wins over a same-cycle return
    end else if (i_inst_sram_data_ok) begin
      req_pending <= 1'b0;
    end
  end

  property p_valid_held;
    @(posedge i_clk) disable iff (!i_arst_n)
      (i_fs_to_ds_valid && !i_ds_allowin) |=> (i_fs_to_ds_valid && $stable(i_fs_to_ds_bus));
  endproperty

  property p_no_ren_while_waiting;
    @(posedge i_clk) disable iff (!i_arst_n)
      (i_fs_to_ds_valid && !i_ds_allowin) |-> !i_inst_sram_ren;
  endproperty

  property p_data_ok_outstanding;
    @(posedge i_clk) disable iff (!i_arst_n)
      i_inst_sram_data_ok |-> req_pending;
  endproperty

  property p_pc_aligned;
    @(posedge i_clk) disable iff (!i_arst_n)
      i_fs_to_ds_valid |-> (i_fs_to_ds_bus.pc[1:0] == 2'b00);
  endproperty

  a_valid_held: assert property (p_valid_held)
    else $error("valid dropped or bus changed while decode stalled");
  a_no_ren_while_waiting: assert property (p_no_ren_while_waiting)
    else $error("sram read enabled while valid waits on decode");
  a_data_ok_outstanding: assert property (p_data_ok_outstanding)
    else $error("data_ok without an outstanding request");
  a_pc_aligned: assert property (p_pc_aligned)
    else $error("bus pc not word aligned");

endmodule

bind fetch_top fetch_checker u_checker (
  .i_clk               (i_clk),
  .i_arst_n            (i_arst_n),
  .i_ds_allowin        (i_ds_allowin),
  .i_br_bus            (i_br_bus),
  .i_fs_to_ds_valid    (o_fs_to_ds_valid),
  .i_fs_to_ds_bus      (o_fs_to_ds_bus),
  .i_inst_sram_ren     (o_inst_sram_ren),
  .i_inst_sram_addr_ok (i_inst_sram_addr_ok),
  .i_inst_sram_data_ok (i_inst_sram_data_ok)
);

`default_nettype wire

//--- tb/fetch_tb.sv
// instruction fetch testbench
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;

  localparam int     CLK_PERIOD      = 8;
  localparam int     RESET_CYCLES    = 5;
  localparam int     NUM_XFERS       = 3000;
  localparam int     CYCLES_PER_XFER = 40;
  localparam int     SEED            = 715;
  localparam longint WATCHDOG_NS     = longint'(NUM_XFERS) * CYCLES_PER_XFER * CLK_PERIOD;

  logic                      clk;
  logic                      arst_n;
  logic                      ds_allowin;
  fetch_pkg::br_bus_t        br_bus;
  logic                      fs_valid;
  fetch_pkg::fs_to_ds_bus_t  fs_bus;
  logic                      sram_ren;
  fetch_pkg::pc_t            sram_addr;
  fetch_pkg::sram_data_t     sram_rdata;
  logic                      sram_addr_ok;
  logic                      sram_data_ok;

  logic [6:0] opc_tab [8];  // opcode mix of the memory image

  // reference model state
  fetch_pkg::pc_t            load_q[$];
  fetch_pkg::pc_t            next_seq;
  fetch_pkg::pc_t            req_addr;   // address the sram is serving
  logic                      sram_busy;
  int unsigned               wait_cnt;
  logic                      busy;       // loaded and not yet taken by decode
  logic                      arrived;    // data back while decode not ready
  logic                      held;
  fetch_pkg::fs_to_ds_bus_t  held_bus;
  logic                      seen_data_ok;
  int                        errors;
  int                        xfers;
  int                        loads;

  fetch_top UUT (
    .i_clk               (clk),
    .i_arst_n            (arst_n),
    .i_ds_allowin        (ds_allowin),
    .i_br_bus            (br_bus),
    .o_fs_to_ds_valid    (fs_valid),
    .o_fs_to_ds_bus      (fs_bus),
    .o_inst_sram_ren     (sram_ren),
    .o_inst_sram_addr    (sram_addr),
    .i_inst_sram_rdata   (sram_rdata),
    .i_inst_sram_addr_ok (sram_addr_ok),
    .i_inst_sram_data_ok (sram_data_ok)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic count_mismatch(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
    $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic log_failure(input string msg);
    $display("failure at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic pick_opcodes();
    logic [6:0] pool [6];
    pool = '{7'b0010011, 7'b0110011, 7'b0000011, 7'b0100011, 7'b0110111, 7'b0010111};
    opc_tab[0] = 7'b1100011;  // control flow always present
    opc_tab[1] = 7'b1101111;
    opc_tab[2] = 7'b1100111;
    for (int i = 3; i < 8; i++) begin
      opc_tab[i] = pool[$urandom % 6];
    end
  endtask

  // image word hashed from the whole word address
  function automatic fetch_pkg::inst_t mem_inst(input fetch_pkg::pc_t addr);
    logic [31:0] h;
    h = {addr[31:2], 2'b01} * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    return {h[31:7], opc_tab[h[2:0]]};
  endfunction

  function automatic fetch_pkg::sram_data_t sram_word(input fetch_pkg::pc_t addr);
    return {mem_inst({addr[31:3], 3'b100}), mem_inst({addr[31:3], 3'b000})};
  endfunction

  function automatic fetch_pkg::predecode_t predecode_of(input fetch_pkg::inst_t inst);
    fetch_pkg::predecode_t pd;
    pd.is_branch = (inst[6:0] == 7'b1100011);
    pd.is_jal    = (inst[6:0] == 7'b1101111);
    pd.is_jalr   = (inst[6:0] == 7'b1100111);
    return pd;
  endfunction

  task automatic drive_inputs();
    ds_allowin    = ($urandom % 100) < 60;
    br_bus.stall  = ($urandom % 100) < 10;
    br_bus.taken  = ($urandom % 100) < 15;
    br_bus.target = $urandom & 32'hffff_fffc;
    sram_data_ok  = 1'b0;
    sram_rdata    = {$urandom, $urandom};  // junk unless data_ok
    if (sram_busy) begin
      wait_cnt--;
      if (wait_cnt == 0) begin
        sram_data_ok = 1'b1;
        sram_rdata   = sram_word(req_addr);
        sram_busy    = 1'b0;
      end
    end
    sram_addr_ok = !sram_busy && (($urandom % 100) < 70);
  endtask

  // sampled at the falling edge when inputs have settled
  task automatic check_cycle();
    logic                  load;
    logic                  xfer;
    logic                  exp_valid;
    logic                  exp_ren;
    fetch_pkg::pc_t        exp_addr;
    fetch_pkg::pc_t        exp_pc;
    fetch_pkg::sram_data_t word;
    fetch_pkg::inst_t      exp_inst;

    exp_valid = busy && (sram_data_ok || arrived);
    exp_ren   = !busy || (exp_valid && ds_allowin);
    if (fs_valid !== exp_valid) count_mismatch("fs_to_ds_valid", fs_valid, exp_valid);
    if (sram_ren !== exp_ren) count_mismatch("inst_sram_ren", sram_ren, exp_ren);
    if (sram_data_ok) seen_data_ok = 1'b1;
    if (!seen_data_ok && fs_valid) log_failure("valid high before any data_ok");

    if (held) begin
      if (!fs_valid) log_failure("valid dropped under back-pressure");
      if (fs_bus !== held_bus) log_failure("bus changed under back-pressure");
    end
    if (fs_valid && !ds_allowin && sram_ren) log_failure("read enabled under back-pressure");

    load = sram_ren && sram_addr_ok && !br_bus.stall;
    xfer = fs_valid && ds_allowin;

    if (xfer) begin
      if (load_q.size() == 0) begin
        log_failure("transfer with no request loaded");
      end else begin
        exp_pc   = load_q.pop_front();
        word     = sram_word(exp_pc);
        exp_inst = exp_pc[2] ? word[63:32] : word[31:0];
        if (fs_bus.pc !== exp_pc) count_mismatch("bus pc", fs_bus.pc, exp_pc);
        if (fs_bus.inst !== exp_inst) count_mismatch("bus inst", fs_bus.inst, exp_inst);
        if (fs_bus.predecode !== predecode_of(exp_inst)) begin
          count_mismatch("predecode", fs_bus.predecode, predecode_of(exp_inst));
        end
      end
      xfers++;
      busy    = 1'b0;
      arrived = 1'b0;
    end else if (busy && sram_data_ok) begin
      arrived = 1'b1;
    end

    if (load) begin
      exp_addr = br_bus.taken ? br_bus.target : next_seq;
      if (sram_addr !== exp_addr) count_mismatch("request address", sram_addr, exp_addr);
      next_seq = exp_addr + 32'd4;
      load_q.push_back(exp_addr);
      req_addr  = sram_addr;  // sram serves what it was given
      sram_busy = 1'b1;
      wait_cnt  = 1 + ($urandom % 3);
      busy      = 1'b1;
      loads++;
    end

    held     = fs_valid && !ds_allowin;
    held_bus = fs_bus;
  endtask

  initial begin
    int unsigned seed_rnd;
    clk          = 1'b0;
    arst_n       = 1'b0;
    ds_allowin   = 1'b0;
    br_bus       = '0;
    sram_rdata   = '0;
    sram_addr_ok = 1'b0;
    sram_data_ok = 1'b0;
    next_seq     = fetch_pkg::PC_RESETVAL;
    req_addr     = '0;
    sram_busy    = 1'b0;
    wait_cnt     = 0;
    busy         = 1'b0;
    arrived      = 1'b0;
    held         = 1'b0;
    held_bus     = '0;
    seen_data_ok = 1'b0;
    errors       = 0;
    xfers        = 0;
    loads        = 0;
    seed_rnd     = $urandom(SEED);
    pick_opcodes();

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    if (fs_valid !== 1'b0) log_failure("valid not low after reset");
    if (sram_ren !== 1'b1) log_failure("read enable not high after reset");

    while (xfers < NUM_XFERS) begin
      drive_inputs();
      @(negedge clk);
      check_cycle();
      @(posedge clk);
      #1;
    end

    $display("done: %0d transfers, %0d loads, %0d errors", xfers, loads, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // bound on run time with a generous budget per transfer
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t ns, only %0d of %0d transfers done",
             $time, xfers, NUM_XFERS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
src/fetch_pkg.sv
src/fetch_pc.sv
src/fetch_ifu.sv
src/fetch_hold_buf.sv
src/fetch_stage.sv
src/fetch_top.sv
tb/fetch_checker.sv
tb/fetch_tb.sv
